/* src/tsc_settings.svh */
`ifndef TSC_SETTINGS_SVH
`define TSC_SETTINGS_SVH

// datapath widths
`define TSC_WORD_W 16
`define TSC_REG_W 2
`define TSC_IMM_W 8

// opcodes, instr[15:12]
`define TSC_OP_BNE 4'd0
`define TSC_OP_BEQ 4'd1
`define TSC_OP_ADI 4'd4
`define TSC_OP_LWD 4'd7
`define TSC_OP_SWD 4'd8
`define TSC_OP_RTYPE 4'd15

// r-type function codes, instr[5:0]
`define TSC_FN_ADD 6'd0
`define TSC_FN_SUB 6'd1
`define TSC_FN_AND 6'd2
`define TSC_FN_ORR 6'd3
`define TSC_FN_WWD 6'd28
`define TSC_FN_HLT 6'd29

`define TSC_NOP {`TSC_OP_RTYPE, 6'd0, `TSC_FN_ADD}  // add r0, r0, r0
`define TSC_RESET_PC 16'd0

`endif

/* src/tsc_pkg.sv */
`default_nettype none

`include "tsc_settings.svh"

package tsc_pkg;

    typedef logic [`TSC_WORD_W-1:0] word_t;
    typedef logic [`TSC_REG_W-1:0]  reg_idx_t;
    typedef logic [3:0]             opcode_t;
    typedef logic [5:0]             funct_t;
    typedef logic [`TSC_IMM_W-1:0]  imm_t;
    typedef logic [1:0]             alu_op_t;  // same encoding as funct[1:0]

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     use_imm;
        logic     wwd;
        logic     halt;
        alu_op_t  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm_ext;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     wwd;
        logic     halt;
        reg_idx_t dest;
        word_t    alu_out;    // also the load/store address
        word_t    store_val;
        word_t    wwd_val;
    } ex_mem_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    value;
        logic     load_pending;  // value not usable yet
    } fwd_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

/* src/tsc_regfile.sv */
`default_nettype none

`include "tsc_settings.svh"

module tsc_regfile (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire tsc_pkg::reg_idx_t rs,
    input  wire tsc_pkg::reg_idx_t rt,
    input  wire tsc_pkg::wb_t      wb,
    output tsc_pkg::word_t         rs_val,
    output tsc_pkg::word_t         rt_val
);

    tsc_pkg::word_t regs [2**`TSC_REG_W];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 2**`TSC_REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-back seen by decode in the same cycle
    assign rs_val = (wb.we && wb.dest == rs) ? wb.data : regs[rs];
    assign rt_val = (wb.we && wb.dest == rt) ? wb.data : regs[rt];

endmodule

`default_nettype wire

/* src/tsc_decode.sv */
`default_nettype none

`include "tsc_settings.svh"

module tsc_decode (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    hold,
    input  wire                    is_halted,
    input  wire tsc_pkg::word_t    imem_data,
    output tsc_pkg::word_t         imem_addr,
    output tsc_pkg::reg_idx_t      rs,
    output tsc_pkg::reg_idx_t      rt,
    input  wire tsc_pkg::word_t    rs_val,
    input  wire tsc_pkg::word_t    rt_val,
    input  wire tsc_pkg::fwd_t     ex_fwd,
    input  wire tsc_pkg::fwd_t     mem_fwd,
    output tsc_pkg::id_ex_t        id_ex
);

    tsc_pkg::word_t    pc;
    logic              if_valid;
    tsc_pkg::word_t    if_instr;
    tsc_pkg::word_t    if_pc;
    logic              fetch_stop;     // HLT has left decode

    tsc_pkg::opcode_t  op;
    tsc_pkg::funct_t   fn;
    tsc_pkg::imm_t     imm;
    tsc_pkg::reg_idx_t rd;
    tsc_pkg::word_t    imm_ext;

    logic is_rtype, is_alu_r, is_wwd, is_hlt;
    logic is_adi, is_lwd, is_swd, is_branch;
    logic use_rs, use_rt;
    logic ex_hit_rs, ex_hit_rt, mem_hit_rs, mem_hit_rt;
    logic stall, taken, fetch_en;

    tsc_pkg::word_t    br_a;
    tsc_pkg::word_t    br_b;
    tsc_pkg::word_t    br_target;
    tsc_pkg::id_ex_t   dec;

    assign imem_addr = pc;

    ////////////////////////////////////////////////////////////////////////////
    // field split and control

    assign op  = if_instr[15:12];
    assign rs  = if_instr[11:10];
    assign rt  = if_instr[9:8];
    assign rd  = if_instr[7:6];
    assign fn  = if_instr[5:0];
    assign imm = if_instr[`TSC_IMM_W-1:0];
    assign imm_ext = {{(`TSC_WORD_W-`TSC_IMM_W){imm[`TSC_IMM_W-1]}}, imm};

    assign is_rtype  = (op == `TSC_OP_RTYPE);
    assign is_alu_r  = is_rtype && (fn == `TSC_FN_ADD || fn == `TSC_FN_SUB ||
                                    fn == `TSC_FN_AND || fn == `TSC_FN_ORR);
    assign is_wwd    = is_rtype && (fn == `TSC_FN_WWD);
    assign is_hlt    = is_rtype && (fn == `TSC_FN_HLT);
    assign is_adi    = (op == `TSC_OP_ADI);
    assign is_lwd    = (op == `TSC_OP_LWD);
    assign is_swd    = (op == `TSC_OP_SWD);
    assign is_branch = (op == `TSC_OP_BEQ) || (op == `TSC_OP_BNE);

    assign use_rs = !is_hlt;
    assign use_rt = is_alu_r || is_swd || is_branch;

    always_comb begin
        dec           = '0;
        dec.valid     = if_valid;
        dec.reg_write = if_valid && (is_alu_r || is_adi || is_lwd);
        dec.mem_read  = if_valid && is_lwd;
        dec.mem_write = if_valid && is_swd;
        dec.use_imm   = is_adi || is_lwd || is_swd;
        dec.wwd       = if_valid && is_wwd;
        dec.halt      = if_valid && is_hlt;
        dec.alu_op    = is_alu_r ? tsc_pkg::alu_op_t'(fn[1:0]) : '0;  // add for addresses
        dec.rs        = rs;
        dec.rt        = rt;
        dec.dest      = is_rtype ? rd : rt;
        dec.rs_val    = rs_val;
        dec.rt_val    = rt_val;
        dec.imm_ext   = imm_ext;
    end

    ////////////////////////////////////////////////////////////////////////////
    // hazards and branch resolution

    assign ex_hit_rs  = ex_fwd.we && ex_fwd.dest == rs;
    assign ex_hit_rt  = ex_fwd.we && ex_fwd.dest == rt;
    assign mem_hit_rs = mem_fwd.we && mem_fwd.dest == rs;
    assign mem_hit_rt = mem_fwd.we && mem_fwd.dest == rt;

    // load in execute, or a load still in memory feeding a branch
    assign stall = if_valid && (
        (ex_fwd.load_pending && ((ex_hit_rs && use_rs) || (ex_hit_rt && use_rt))) ||
        (is_branch && mem_fwd.load_pending && (mem_hit_rs || mem_hit_rt)));

    assign br_a = ex_hit_rs ? ex_fwd.value : (mem_hit_rs ? mem_fwd.value : rs_val);
    assign br_b = ex_hit_rt ? ex_fwd.value : (mem_hit_rt ? mem_fwd.value : rt_val);
    assign br_target = if_pc + tsc_pkg::word_t'(1) + imm_ext;

    assign taken = if_valid && is_branch && !stall &&
                   ((br_a == br_b) == (op == `TSC_OP_BEQ));

    assign fetch_en = !fetch_stop && !is_halted && !dec.halt;

    ////////////////////////////////////////////////////////////////////////////
    // pc, IF/ID and ID/EX

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc         <= `TSC_RESET_PC;
            if_valid   <= 1'b0;
            if_instr   <= `TSC_NOP;
            fetch_stop <= 1'b0;
            id_ex      <= '0;
        end else if (!hold) begin
            if (stall) begin
                id_ex <= '0;  // bubble, IF/ID and pc stay
            end else begin
                id_ex <= dec;
                if (dec.halt) begin
                    fetch_stop <= 1'b1;
                end
                if (taken) begin
                    pc       <= br_target;
                    if_valid <= 1'b0;      // drop the wrong-path fetch
                    if_instr <= `TSC_NOP;
                end else if (fetch_en) begin
                    pc       <= pc + tsc_pkg::word_t'(1);
                    if_valid <= 1'b1;
                    if_instr <= imem_data;
                    if_pc    <= pc;
                end else begin
                    if_valid <= 1'b0;
                    if_instr <= `TSC_NOP;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/tsc_execute.sv */
`default_nettype none

`include "tsc_settings.svh"

module tsc_execute (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    hold,
    input  wire tsc_pkg::id_ex_t   id_ex,
    input  wire tsc_pkg::fwd_t     mem_fwd,
    input  wire tsc_pkg::wb_t      wb,
    output tsc_pkg::fwd_t          ex_fwd,
    output tsc_pkg::ex_mem_t       ex_mem
);

    tsc_pkg::word_t op_a;
    tsc_pkg::word_t op_b_reg;
    tsc_pkg::word_t op_b;
    tsc_pkg::word_t alu_out;

    // newest producer wins
    function automatic tsc_pkg::word_t pick(
        input tsc_pkg::reg_idx_t idx,
        input tsc_pkg::word_t    dec_val,
        input tsc_pkg::fwd_t     mf,
        input tsc_pkg::wb_t      w
    );
        if (mf.we && mf.dest == idx) begin
            return mf.value;
        end
        if (w.we && w.dest == idx) begin
            return w.data;
        end
        return dec_val;
    endfunction

    assign op_a     = pick(id_ex.rs, id_ex.rs_val, mem_fwd, wb);
    assign op_b_reg = pick(id_ex.rt, id_ex.rt_val, mem_fwd, wb);
    assign op_b     = id_ex.use_imm ? id_ex.imm_ext : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            tsc_pkg::alu_op_t'(`TSC_FN_SUB): alu_out = op_a - op_b;
            tsc_pkg::alu_op_t'(`TSC_FN_AND): alu_out = op_a & op_b;
            tsc_pkg::alu_op_t'(`TSC_FN_ORR): alu_out = op_a | op_b;
            default:                         alu_out = op_a + op_b;
        endcase
    end

    // branch operands in decode see this too
    assign ex_fwd = '{
        we:           id_ex.valid && id_ex.reg_write,
        dest:         id_ex.dest,
        value:        alu_out,
        load_pending: id_ex.valid && id_ex.mem_read
    };

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem <= '0;
        end else if (!hold) begin
            ex_mem.valid     <= id_ex.valid;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.wwd       <= id_ex.wwd;
            ex_mem.halt      <= id_ex.halt;
            ex_mem.dest      <= id_ex.dest;
            ex_mem.alu_out   <= alu_out;
            ex_mem.store_val <= op_b_reg;  // rt for SWD
            ex_mem.wwd_val   <= op_a;
        end
    end

endmodule

`default_nettype wire

/* src/tsc_result.sv */
`default_nettype none

module tsc_result (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire tsc_pkg::ex_mem_t  ex_mem,
    output tsc_pkg::dmem_req_t     dmem_req,
    input  wire                    dmem_ready,
    input  wire tsc_pkg::word_t    dmem_rdata,
    output logic                   hold,
    output tsc_pkg::fwd_t          mem_fwd,
    output tsc_pkg::wb_t           wb,
    output tsc_pkg::word_t         output_port,
    output logic                   out_valid,
    output tsc_pkg::word_t         num_inst,
    output logic                   is_halted
);

    logic         mem_op;
    logic         retire;
    logic         mw_valid;
    logic         mw_wwd;
    logic         mw_halt;
    tsc_pkg::wb_t mw;       // MEM/WB write-back part

    ////////////////////////////////////////////////////////////////////////////
    // data memory

    assign mem_op = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    assign dmem_req = '{
        valid: mem_op,
        write: ex_mem.mem_write,
        addr:  ex_mem.alu_out,
        wdata: ex_mem.store_val
    };

    assign hold = mem_op && !dmem_ready;  // freezes every stage

    // load data only exists after the handshake
    assign mem_fwd = '{
        we:           ex_mem.valid && ex_mem.reg_write,
        dest:         ex_mem.dest,
        value:        ex_mem.alu_out,
        load_pending: ex_mem.valid && ex_mem.mem_read
    };

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mw_valid <= 1'b0;
            mw_wwd   <= 1'b0;
            mw_halt  <= 1'b0;
            mw       <= '0;
        end else if (!hold) begin
            mw_valid <= ex_mem.valid;
            mw_wwd   <= ex_mem.wwd;
            mw_halt  <= ex_mem.halt;
            mw.we    <= ex_mem.valid && ex_mem.reg_write;
            mw.dest  <= ex_mem.dest;
            if (ex_mem.mem_read) begin
                mw.data <= dmem_rdata;
            end else if (ex_mem.wwd) begin
                mw.data <= ex_mem.wwd_val;
            end else begin
                mw.data <= ex_mem.alu_out;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write-back and retirement

    assign retire = mw_valid && !hold;
    assign wb     = '{we: mw.we && retire, dest: mw.dest, data: mw.data};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            out_valid   <= 1'b0;
            is_halted   <= 1'b0;
        end else begin
            out_valid <= retire && mw_wwd;
            if (retire) begin
                num_inst <= num_inst + tsc_pkg::word_t'(1);  // HLT included
                if (mw_wwd) begin
                    output_port <= mw.data;
                end
                if (mw_halt) begin
                    is_halted <= 1'b1;  // sticky
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/tsc_core.sv */
`default_nettype none

module tsc_core (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire tsc_pkg::word_t    imem_data,
    input  wire                    dmem_ready,
    input  wire tsc_pkg::word_t    dmem_rdata,
    output tsc_pkg::word_t         imem_addr,
    output tsc_pkg::dmem_req_t     dmem_req,
    output tsc_pkg::word_t         output_port,
    output logic                   out_valid,
    output tsc_pkg::word_t         num_inst,
    output logic                   is_halted
);

    logic              hold;
    tsc_pkg::reg_idx_t rs;
    tsc_pkg::reg_idx_t rt;
    tsc_pkg::word_t    rs_val;
    tsc_pkg::word_t    rt_val;
    tsc_pkg::fwd_t     ex_fwd;
    tsc_pkg::fwd_t     mem_fwd;
    tsc_pkg::wb_t      wb;
    tsc_pkg::id_ex_t   id_ex;
    tsc_pkg::ex_mem_t  ex_mem;

    tsc_decode decode_i (
        .clk, .reset_n, .hold, .is_halted,
        .imem_data, .imem_addr,
        .rs, .rt, .rs_val, .rt_val,
        .ex_fwd, .mem_fwd,
        .id_ex
    );

    tsc_regfile regfile_i (
        .clk, .reset_n,
        .rs, .rt, .wb,
        .rs_val, .rt_val
    );

    tsc_execute execute_i (
        .clk, .reset_n, .hold,
        .id_ex, .mem_fwd, .wb,
        .ex_fwd, .ex_mem
    );

    tsc_result result_i (
        .clk, .reset_n,
        .ex_mem,
        .dmem_req, .dmem_ready, .dmem_rdata,
        .hold, .mem_fwd, .wb,
        .output_port, .out_valid, .num_inst, .is_halted
    );

endmodule

`default_nettype wire

/* tb/tsc_clock_gen.sv */
`default_nettype none

module tsc_clock_gen (
    input  wire  reset_req,
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk_q = 1'b0;
    logic       rst_q = 1'b1;      // in reset from time 0
    logic       req_seen = 1'b0;
    logic [2:0] cycles_left = 3'd4;

    always #10 clk_q = ~clk_q;

    always @(posedge clk_q) begin
        req_seen <= reset_req;
    end

    // reset changes only on falling edges, five rising edges inside it
    always @(negedge clk_q) begin
        if (req_seen) begin
            rst_q       <= 1'b1;
            cycles_left <= 3'd4;
        end else if (cycles_left != 3'd0) begin
            cycles_left <= cycles_left - 3'd1;
        end else begin
            rst_q <= 1'b0;
        end
    end

    assign clk     = clk_q;
    assign reset_n = rst_q;

endmodule

`default_nettype wire

/* tb/tsc_assert.sv */
`default_nettype none

module tsc_assert (
    input wire                     clk,
    input wire                     reset_n,
    input wire tsc_pkg::dmem_req_t dmem_req,
    input wire                     dmem_ready,
    input wire                     out_valid,
    input wire                     is_halted
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // a waiting request holds still
    req_stable: assert property (@(posedge clk) disable iff (reset_n)
        dmem_req.valid && !dmem_ready |=> $stable(dmem_req))
        else begin
            $error("data memory request changed while waiting for ready");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        !$fell(is_halted))
        else begin
            $error("is_halted dropped outside reset");
            fail_count++;
        end

    halt_quiet: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |-> !out_valid && !dmem_req.valid)
        else begin
            $error("output or memory activity after halt");
            fail_count++;
        end

endmodule

bind tsc_core tsc_assert assert_i (
    .clk, .reset_n, .dmem_req, .dmem_ready, .out_valid, .is_halted
);

`default_nettype wire

/* tb/tsc_tb.sv */
`default_nettype none

`include "tsc_settings.svh"

module tsc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN  = 40;
    localparam int NUM_TESTS = 8;
    localparam int RUN_LIMIT = 2000;
    localparam tsc_pkg::word_t HLT_WORD = {`TSC_OP_RTYPE, 6'd0, `TSC_FN_HLT};
    localparam tsc_pkg::word_t PAST_END_WORD = {`TSC_OP_RTYPE, 6'd0, `TSC_FN_WWD};

    logic               clk, reset_n, reset_req, dmem_ready, out_valid, is_halted;
    tsc_pkg::word_t     imem_addr, imem_data, dmem_rdata, output_port, num_inst;
    tsc_pkg::dmem_req_t dmem_req;

    tsc_pkg::word_t prog [PROG_LEN];
    tsc_pkg::word_t dmem [256];
    tsc_pkg::word_t model_mem [256];
    tsc_pkg::word_t exp_q[$];
    tsc_pkg::word_t got_q[$];
    int             exp_count;
    logic [31:0]    rng_state = 32'd49;
    int             checks_failed = 0;
    int             tests_failed = 0;

    tsc_clock_gen clock_gen_i (.reset_req, .clk, .reset_n);

    tsc_core dut_i (
        .clk, .reset_n, .imem_data, .dmem_ready, .dmem_rdata,
        .imem_addr, .dmem_req, .output_port, .out_valid, .num_inst, .is_halted
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic tsc_pkg::word_t fill_word(input int a);
        return tsc_pkg::word_t'(a * 40503 + 17);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // memories around the core

    // a wwd past the end shows up if fetch runs on after HLT
    assign imem_data = (imem_addr < 16'(PROG_LEN)) ? prog[imem_addr[5:0]] : PAST_END_WORD;
    assign dmem_rdata = dmem[dmem_req.addr[7:0]];  // array wraps at 256 words

    always @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_req.valid && dmem_req.write && dmem_ready) begin
            dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
        end
    end

    always @(negedge clk) begin
        if (reset_n) begin
            got_q.delete();
        end else if (out_valid) begin
            got_q.push_back(output_port);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // program generator and ISA model

    // kinds: 0 alu, 1 adi, 2 lwd, 3 swd, 4 branch, 5 wwd
    task automatic gen_program(input int cat);
        logic [5:0]  allowed;
        logic [2:0]  kind;
        logic [31:0] r;
        logic [1:0]  rs, rt, rd;
        int          max_off;
        case (cat)
            0:       allowed = 6'b100011;
            1:       allowed = 6'b101111;
            2:       allowed = 6'b110011;
            default: allowed = 6'b111111;
        endcase
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r    = next_rand();
            rs   = r[1:0];
            rt   = r[3:2];
            rd   = r[5:4];
            kind = 3'(r[15:8] % 8'd6);
            while (!allowed[kind]) begin
                kind = (kind == 3'd5) ? 3'd0 : kind + 3'd1;
            end
            case (kind)
                3'd0: prog[i] = {`TSC_OP_RTYPE, rs, rt, rd, 4'd0, r[7:6]};
                3'd1: prog[i] = {`TSC_OP_ADI, rs, rt, r[23:16]};
                3'd2: prog[i] = {`TSC_OP_LWD, rs, rt, r[23:16]};
                3'd3: prog[i] = {`TSC_OP_SWD, rs, rt, r[23:16]};
                3'd4: begin
                    max_off = PROG_LEN - 2 - i;  // forward, never past HLT
                    if (max_off > 7) begin
                        max_off = 7;
                    end
                    prog[i] = {r[24] ? `TSC_OP_BEQ : `TSC_OP_BNE, rs, r[26] ? rs : rt,
                               8'(int'(r[31:25]) % (max_off + 1))};
                end
                default: prog[i] = {`TSC_OP_RTYPE, rs, 4'd0, `TSC_FN_WWD};
            endcase
        end
        prog[PROG_LEN-1] = HLT_WORD;
    endtask

    task automatic run_model();
        tsc_pkg::word_t regs [4];
        tsc_pkg::word_t ins, a, b, imm;
        int             pc;
        logic           done;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = fill_word(i);
        end
        exp_q.delete();
        exp_count = 0;
        pc        = 0;
        done      = 1'b0;
        while (!done && pc < PROG_LEN) begin
            ins = prog[pc];
            a   = regs[ins[11:10]];
            b   = regs[ins[9:8]];
            imm = {{8{ins[7]}}, ins[7:0]};
            exp_count++;
            pc++;
            case (ins[15:12])
                `TSC_OP_ADI: regs[ins[9:8]] = a + imm;
                `TSC_OP_LWD: regs[ins[9:8]] = model_mem[8'(a + imm)];
                `TSC_OP_SWD: model_mem[8'(a + imm)] = b;
                `TSC_OP_BEQ: pc = (a == b) ? pc + int'($signed(imm)) : pc;
                `TSC_OP_BNE: pc = (a != b) ? pc + int'($signed(imm)) : pc;
                `TSC_OP_RTYPE: begin
                    case (ins[5:0])
                        `TSC_FN_ADD: regs[ins[7:6]] = a + b;
                        `TSC_FN_SUB: regs[ins[7:6]] = a - b;
                        `TSC_FN_AND: regs[ins[7:6]] = a & b;
                        `TSC_FN_ORR: regs[ins[7:6]] = a | b;
                        `TSC_FN_WWD: exp_q.push_back(a);
                        `TSC_FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one program from reset to halt

    task automatic run_test(input int t);
        string kind_name, name;
        int    cycles, errs_before, n_after;
        logic  mem_bad;
        case (t % 4)
            0:       kind_name = "alu_fwd";
            1:       kind_name = "load_store";
            2:       kind_name = "branch";
            default: kind_name = "mixed";
        endcase
        name        = $sformatf("%s_%0d", kind_name, t);
        errs_before = checks_failed;
        gen_program(t % 4);
        run_model();

        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        cycles = 0;
        while (!reset_n && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        while (reset_n && cycles < 30) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_n) begin
            $display("test %s: reset never finished", name);
            checks_failed++;
        end
        @(negedge clk);
        if ({out_valid, is_halted, dmem_req.valid, num_inst} !== 19'h0) begin
            $display("FAIL %s reset_state expected %h actual %h", name, 19'h0,
                     {out_valid, is_halted, dmem_req.valid, num_inst});
            checks_failed++;
        end

        cycles = 0;
        while (!is_halted && cycles < RUN_LIMIT) begin
            dmem_ready = (next_rand() & 32'd3) != 32'd0;  // about 75% ready
            @(negedge clk);
            cycles++;
        end
        if (!is_halted) begin
            $display("test %s: timed out after %0d cycles waiting for halt", name, cycles);
            checks_failed++;
        end else begin
            if (got_q.size() != exp_q.size()) begin
                $display("FAIL %s wwd_count expected %0d actual %0d", name,
                         exp_q.size(), got_q.size());
                checks_failed++;
            end
            for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
                if (got_q[i] !== exp_q[i]) begin
                    $display("FAIL %s wwd[%0d] expected %h actual %h", name, i,
                             exp_q[i], got_q[i]);
                    checks_failed++;
                end
            end
            if (num_inst !== 16'(exp_count)) begin
                $display("FAIL %s num_inst expected %0d actual %0d", name, exp_count, num_inst);
                checks_failed++;
            end
            mem_bad = 1'b0;
            for (int i = 0; i < 256; i++) begin
                if (!mem_bad && dmem[i] !== model_mem[i]) begin
                    $display("FAIL %s dmem[%0d] expected %h actual %h", name, i,
                             model_mem[i], dmem[i]);
                    checks_failed++;
                    mem_bad = 1'b1;
                end
            end
            n_after = got_q.size();
            repeat (20) @(negedge clk);
            if (got_q.size() != n_after) begin
                $display("FAIL %s wwd_after_halt expected %0d actual %0d", name,
                         n_after, got_q.size());
                checks_failed++;
            end
        end

        if (checks_failed == errs_before) begin
            $display("test %s: ok, %0d outputs, %0d retired", name, exp_q.size(), exp_count);
        end else begin
            $display("test %s: %0d checks failed", name, checks_failed - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int assert_fails;
        reset_req  = 1'b0;
        dmem_ready = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        assert_fails = dut_i.assert_i.fail_count;
        $display("tests %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
                 NUM_TESTS, tests_failed, checks_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/tsc_pkg.sv
src/tsc_regfile.sv
src/tsc_decode.sv
src/tsc_execute.sv
src/tsc_result.sv
src/tsc_core.sv
tb/tsc_clock_gen.sv
tb/tsc_assert.sv
tb/tsc_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tsc_tb -f all.f || exit 1
out=$(./obj_dir/Vtsc_tb +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Regression passed' && exit 0 || exit 1
